/* uc_pkg.sv */
package uc_pkg;

    // problem size
    localparam int uc_len = 64;
    localparam int var_w = 6;
    localparam int num_engine = 4;
    localparam int queue_depth = 8;

    // derived widths
    localparam int count_w = $clog2(uc_len + 1);
    localparam int q_ptr_w = $clog2(queue_depth);
    localparam int q_cnt_w = $clog2(queue_depth + 1);
    localparam int apb_addr_w = 4;
    localparam int apb_data_w = 32;

    // literal as seen on every port, neg set means negative polarity
    typedef struct packed {
        logic             neg;
        logic [var_w-1:0] idx;
    } lit_t;

    // head of one engine fifo
    typedef struct packed {
        logic empty;
        lit_t lit;
    } eng_port_t;

    typedef enum logic [1:0] {
        arb_idle = 2'b00,
        arb_scan = 2'b01,
        arb_done = 2'b10
    } arb_state_t;

    typedef enum logic [apb_addr_w-1:0] {
        reg_lit    = 4'h0,
        reg_ctrl   = 4'h4,
        reg_status = 4'h8,
        reg_count  = 4'hC
    } apb_addr_t;

    // status word, conflict in bit 7
    typedef struct packed {
        logic             conflict;
        logic             busy;
        logic [var_w-1:0] idx;
    } status_t;

endpackage

/* uc_apb_regs.sv */
`timescale 1ns/1ps

module uc_apb_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [uc_pkg::apb_addr_w-1:0] paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [uc_pkg::apb_data_w-1:0] pwdata,
    input  logic                          seed_ready,
    input  uc_pkg::status_t               status,
    input  logic [uc_pkg::count_w-1:0]    count,
    output logic [uc_pkg::apb_data_w-1:0] prdata,
    output logic                          pready,
    output logic                          seed_valid,
    output uc_pkg::lit_t                  seed_lit,
    output logic                          start,
    output logic                          clear
);

    uc_pkg::apb_addr_t             addr;
    logic                          setup_rd;
    logic                          access;
    logic                          wr_lit;
    logic                          wr_ctrl;
    logic [uc_pkg::apb_data_w-1:0] rd_mux;

    assign addr = uc_pkg::apb_addr_t'(paddr);

    // apb phases
    assign setup_rd = psel && !penable && !pwrite;
    assign access = psel && penable;

    assign wr_lit = access && pwrite && (addr == uc_pkg::reg_lit);
    assign wr_ctrl = access && pwrite && (addr == uc_pkg::reg_ctrl);

    // seed request held through wait states until the arbiter takes it
    assign seed_valid = wr_lit;
    assign seed_lit = uc_pkg::lit_t'(pwdata[$bits(uc_pkg::lit_t)-1:0]);

    // only seed writes can stall the bus
    assign pready = !wr_lit || seed_ready;

    // control pulses, ctrl access never waits so they last one cycle
    assign start = wr_ctrl && pwdata[0];
    assign clear = wr_ctrl && pwdata[1];

    always_comb begin
        rd_mux = '0;
        case (addr)
            uc_pkg::reg_status: begin
                rd_mux = uc_pkg::apb_data_w'(status);
            end
            uc_pkg::reg_count: begin
                rd_mux = uc_pkg::apb_data_w'(count);
            end
            default: begin
                // write only registers read back as zero
                rd_mux = '0;
            end
        endcase
    end

    // capture read data in setup so access returns a flop output
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prdata <= '0;
        end else if (setup_rd) begin
            prdata <= rd_mux;
        end
    end

endmodule

/* uc_arbiter.sv */
`timescale 1ns/1ps

module uc_arbiter (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             seed_valid,
    input  uc_pkg::lit_t                                     seed_lit,
    input  logic                                             start,
    input  logic                                             clear,
    input  uc_pkg::eng_port_t [uc_pkg::num_engine-1:0]       eng_in,
    input  logic                                             q_full,
    output logic                                             seed_ready,
    output logic [uc_pkg::num_engine-1:0]                    eng_take,
    output logic                                             q_push,
    output uc_pkg::lit_t                                     q_lit,
    output uc_pkg::status_t                                  status,
    output logic [uc_pkg::count_w-1:0]                       count
);

    uc_pkg::arb_state_t                   state_r;
    uc_pkg::arb_state_t                   state_nxt;
    logic [uc_pkg::num_engine-1:0]        grant_r;
    logic [uc_pkg::uc_len-1:0][1:0]       tbl_r;
    logic                                 conf_r;
    logic [uc_pkg::var_w-1:0]             conf_idx_r;
    logic [uc_pkg::count_w-1:0]           count_r;
    uc_pkg::eng_port_t                    head;
    logic                                 take;
    logic                                 seed_acc;
    logic                                 acc_valid;
    uc_pkg::lit_t                         acc_lit;
    logic                                 own_set;
    logic                                 opp_set;
    logic                                 is_new;
    logic                                 is_conf;

    // head of the granted engine
    always_comb begin
        head = '0;
        head.empty = 1'b1;
        for (int i = 0; i < uc_pkg::num_engine; i++) begin
            if (grant_r[i]) begin
                head = eng_in[i];
            end
        end
    end

    assign seed_ready = (state_r == uc_pkg::arb_idle) && !q_full;
    assign seed_acc = seed_valid && seed_ready;

    assign take = (state_r == uc_pkg::arb_scan) && !q_full && !head.empty;
    assign eng_take = take ? grant_r : '0;

    // seeds and engine takes never overlap, they live in different states
    assign acc_valid = seed_acc || take;
    assign acc_lit = take ? head.lit : seed_lit;

    // table lookup, one bit per polarity
    assign own_set = tbl_r[acc_lit.idx][acc_lit.neg];
    assign opp_set = tbl_r[acc_lit.idx][!acc_lit.neg];
    assign is_new = acc_valid && !own_set && !opp_set;
    assign is_conf = acc_valid && opp_set;

    assign q_push = is_new;
    assign q_lit = acc_lit;

    assign status.conflict = conf_r;
    assign status.busy = (state_r == uc_pkg::arb_scan);
    assign status.idx = conf_idx_r;
    assign count = count_r;

    always_comb begin
        state_nxt = state_r;
        if (clear) begin
            state_nxt = uc_pkg::arb_idle;
        end else if (is_conf) begin
            state_nxt = uc_pkg::arb_done;
        end else if (state_r == uc_pkg::arb_idle && start) begin
            state_nxt = uc_pkg::arb_scan;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_r <= uc_pkg::arb_idle;
            grant_r <= uc_pkg::num_engine'(1);
            tbl_r <= '0;
            conf_r <= 1'b0;
            conf_idx_r <= '0;
            count_r <= '0;
        end else begin
            state_r <= state_nxt;
            if (clear) begin
                tbl_r <= '0;
                conf_r <= 1'b0;
                conf_idx_r <= '0;
                count_r <= '0;
            end else begin
                if (is_new) begin
                    tbl_r[acc_lit.idx][acc_lit.neg] <= 1'b1;
                    count_r <= count_r + 1'b1;
                end
                // sticky until clear
                if (is_conf) begin
                    conf_r <= 1'b1;
                    conf_idx_r <= acc_lit.idx;
                end
            end
            // rotation freezes while the queue is full
            if (state_r == uc_pkg::arb_scan && !q_full) begin
                grant_r <= {grant_r[uc_pkg::num_engine-2:0], grant_r[uc_pkg::num_engine-1]};
            end
        end
    end

    a_take_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(eng_take));

    // a recorded conflict and its index hold until clear
    a_conf_sticky: assert property (@(posedge clk) disable iff (!rst)
        conf_r && !clear |=> conf_r && $stable(conf_idx_r));

    a_take_scan: assert property (@(posedge clk) disable iff (!rst)
        |eng_take |-> state_r == uc_pkg::arb_scan);

endmodule

/* uc_queue.sv */
`timescale 1ns/1ps

module uc_queue (
    input  logic         clk,
    input  logic         rst,
    input  logic         q_push,
    input  uc_pkg::lit_t q_lit,
    input  logic         out_ready,
    output logic         q_full,
    output logic         out_valid,
    output uc_pkg::lit_t out_lit
);

    uc_pkg::lit_t                 mem [uc_pkg::queue_depth];
    logic [uc_pkg::q_ptr_w-1:0]   wr_ptr;
    logic [uc_pkg::q_ptr_w-1:0]   rd_ptr;
    logic [uc_pkg::q_cnt_w-1:0]   occ;
    logic                         pop;

    assign q_full = (occ == uc_pkg::q_cnt_w'(uc_pkg::queue_depth));
    assign out_valid = (occ != '0);
    assign out_lit = mem[rd_ptr];
    assign pop = out_valid && out_ready;

    // entry storage
    always_ff @(posedge clk) begin
        if (q_push) begin
            mem[wr_ptr] <= q_lit;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ <= '0;
        end else begin
            if (q_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (q_push && !pop) begin
                occ <= occ + 1'b1;
            end else if (pop && !q_push) begin
                occ <= occ - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst)
        !(q_push && q_full));

    // a stalled head stays valid and unchanged
    a_hold_head: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_lit));

endmodule

/* uc_top.sv */
`timescale 1ns/1ps

module uc_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [uc_pkg::apb_addr_w-1:0]              paddr,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [uc_pkg::apb_data_w-1:0]              pwdata,
    output logic [uc_pkg::apb_data_w-1:0]              prdata,
    output logic                                       pready,
    input  uc_pkg::eng_port_t [uc_pkg::num_engine-1:0] eng_in,
    output logic [uc_pkg::num_engine-1:0]              eng_take,
    output logic                                       out_valid,
    output uc_pkg::lit_t                               out_lit,
    input  logic                                       out_ready
);

    logic                       seed_valid;
    logic                       seed_ready;
    uc_pkg::lit_t               seed_lit;
    logic                       start;
    logic                       clear;
    uc_pkg::status_t            status;
    logic [uc_pkg::count_w-1:0] count;
    logic                       q_full;
    logic                       q_push;
    uc_pkg::lit_t               q_lit;

    // host register block
    uc_apb_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .seed_ready (seed_ready),
        .status     (status),
        .count      (count),
        .prdata     (prdata),
        .pready     (pready),
        .seed_valid (seed_valid),
        .seed_lit   (seed_lit),
        .start      (start),
        .clear      (clear)
    );

    uc_arbiter i_arbiter (
        .clk        (clk),
        .rst        (rst),
        .seed_valid (seed_valid),
        .seed_lit   (seed_lit),
        .start      (start),
        .clear      (clear),
        .eng_in     (eng_in),
        .q_full     (q_full),
        .seed_ready (seed_ready),
        .eng_take   (eng_take),
        .q_push     (q_push),
        .q_lit      (q_lit),
        .status     (status),
        .count      (count)
    );

    // broadcast fifo toward the engines
    uc_queue i_queue (
        .clk       (clk),
        .rst       (rst),
        .q_push    (q_push),
        .q_lit     (q_lit),
        .out_ready (out_ready),
        .q_full    (q_full),
        .out_valid (out_valid),
        .out_lit   (out_lit)
    );

endmodule

/* tb_uc_checker.sv */
`timescale 1ns/1ps

module tb_uc_checker (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [uc_pkg::apb_addr_w-1:0]              paddr,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [uc_pkg::apb_data_w-1:0]              pwdata,
    input  logic [uc_pkg::apb_data_w-1:0]              prdata,
    input  logic                                       pready,
    input  uc_pkg::eng_port_t [uc_pkg::num_engine-1:0] eng_in,
    input  logic [uc_pkg::num_engine-1:0]              eng_take,
    input  logic                                       out_valid,
    input  uc_pkg::lit_t                               out_lit,
    input  logic                                       out_ready,
    output int                                         errors,
    output int                                         pending
);

    uc_pkg::arb_state_t             state;
    logic [1:0]                     tbl [uc_pkg::uc_len];
    logic                           conf;
    logic [uc_pkg::var_w-1:0]       conf_idx;
    int                             count;
    uc_pkg::lit_t                   exp_q [$];
    uc_pkg::lit_t                   exp_lit;
    logic [uc_pkg::apb_data_w-1:0]  rd_exp;
    logic                           wr_lit;
    logic                           exp_ready;

    initial begin
        errors = 0;
        pending = 0;
    end

    // new, duplicate or conflict against the model table
    task automatic accept(input uc_pkg::lit_t l);
        if (tbl[l.idx][!l.neg]) begin
            conf = 1'b1;
            conf_idx = l.idx;
            state = uc_pkg::arb_done;
        end else if (!tbl[l.idx][l.neg]) begin
            tbl[l.idx][l.neg] = 1'b1;
            count++;
            exp_q.push_back(l);
        end
    endtask

    task automatic clear_model();
        state = uc_pkg::arb_idle;
        tbl = '{default: 2'b00};
        conf = 1'b0;
        conf_idx = '0;
        count = 0;
    endtask

    // everything is settled at the falling edge, events land on the next rising one
    always @(negedge clk) begin
        if (!rst) begin
            clear_model();
            exp_q.delete();
            rd_exp = '0;
        end else begin
            wr_lit = psel && penable && pwrite && (paddr == uc_pkg::reg_lit);
            exp_ready = !wr_lit ||
                ((state == uc_pkg::arb_idle) && (exp_q.size() < uc_pkg::queue_depth));
            if (pready !== exp_ready) begin
                errors++;
                $display("mismatch pready expected %h actual %h", exp_ready, pready);
            end
            if (psel && penable && !pwrite && pready && (prdata !== rd_exp)) begin
                errors++;
                $display("mismatch prdata expected %h actual %h", rd_exp, prdata);
            end
            // read data is captured in the setup phase
            if (psel && !penable && !pwrite) begin
                case (paddr)
                    uc_pkg::reg_status: begin
                        rd_exp = {24'b0, conf, state == uc_pkg::arb_scan, conf_idx};
                    end
                    uc_pkg::reg_count: begin
                        rd_exp = 32'(count);
                    end
                    default: begin
                        rd_exp = '0;
                    end
                endcase
            end
            if (out_valid !== (exp_q.size() != 0)) begin
                errors++;
                $display("mismatch out_valid expected %h actual %h",
                         exp_q.size() != 0, out_valid);
            end
            if (eng_take != '0) begin
                if (state != uc_pkg::arb_scan) begin
                    errors++;
                    $display("an engine literal was taken while the hub was not scanning");
                end
                if (exp_q.size() >= uc_pkg::queue_depth) begin
                    errors++;
                    $display("an engine literal was taken while the queue was full");
                end
            end
            if (out_valid && out_ready && (exp_q.size() != 0)) begin
                exp_lit = exp_q.pop_front();
                if (out_lit !== exp_lit) begin
                    errors++;
                    $display("mismatch out_lit expected %h actual %h", exp_lit, out_lit);
                end
            end
            for (int i = 0; i < uc_pkg::num_engine; i++) begin
                if (eng_take[i]) begin
                    if (eng_in[i].empty) begin
                        errors++;
                        $display("engine %0d was popped while its fifo was empty", i);
                    end
                    accept(eng_in[i].lit);
                end
            end
            if (wr_lit && pready) begin
                accept(uc_pkg::lit_t'(pwdata[$bits(uc_pkg::lit_t)-1:0]));
            end
            // clear wins over start
            if (psel && penable && pwrite && pready && (paddr == uc_pkg::reg_ctrl)) begin
                if (pwdata[1]) begin
                    clear_model();
                end else if (pwdata[0] && (state == uc_pkg::arb_idle)) begin
                    state = uc_pkg::arb_scan;
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

/* tb_uc_top.sv */
`timescale 1ns/1ps

module tb_uc_top;

    localparam int clk_period = 100;
    localparam int num_tests = 6;
    localparam int lits_per_test = 20;
    // room for random back-pressure on every literal
    localparam int cycles_per_lit = 20;
    localparam int timeout_ns = (num_tests * lits_per_test * cycles_per_lit + 1000) * clk_period;

    logic                                       clk;
    logic                                       rst;
    logic [uc_pkg::apb_addr_w-1:0]              paddr;
    logic                                       psel;
    logic                                       penable;
    logic                                       pwrite;
    logic [uc_pkg::apb_data_w-1:0]              pwdata;
    logic [uc_pkg::apb_data_w-1:0]              prdata;
    logic                                       pready;
    uc_pkg::eng_port_t [uc_pkg::num_engine-1:0] eng_in;
    logic [uc_pkg::num_engine-1:0]              eng_take;
    logic                                       out_valid;
    uc_pkg::lit_t                               out_lit;
    logic                                       out_ready;
    int                                         errors;
    int                                         pending;
    int                                         seed;
    logic                                       stall;
    logic [uc_pkg::num_engine-1:0]              take_seen;
    uc_pkg::lit_t                               eng_list [uc_pkg::num_engine][$];
    logic                                       used [uc_pkg::uc_len];
    int                                         test_num;
    int                                         tests_failed;
    int                                         err_before;

    uc_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .eng_in    (eng_in),
        .eng_take  (eng_take),
        .out_valid (out_valid),
        .out_lit   (out_lit),
        .out_ready (out_ready)
    );

    tb_uc_checker i_chk (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .eng_in    (eng_in),
        .eng_take  (eng_take),
        .out_valid (out_valid),
        .out_lit   (out_lit),
        .out_ready (out_ready),
        .errors    (errors),
        .pending   (pending)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(negedge clk) take_seen = eng_take;

    // engine fifos and the random sink
    always @(posedge clk) begin : drive_engines
        int r;
        #1;
        for (int i = 0; i < uc_pkg::num_engine; i++) begin
            if (take_seen[i] && (eng_list[i].size() != 0)) begin
                void'(eng_list[i].pop_front());
            end
            eng_in[i].empty = (eng_list[i].size() == 0);
            eng_in[i].lit = (eng_list[i].size() == 0) ? '0 : eng_list[i][0];
        end
        r = $random(seed);
        out_ready = !stall && r[0];
    end

    // one apb transfer, called and returning 1 ns after a rising edge
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        logic done;
        paddr = addr;
        pwdata = data;
        pwrite = wr;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = pready;
            @(posedge clk);
            #1;
        end
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // random literal on a variable not yet used in this problem
    task automatic new_lit(output uc_pkg::lit_t l);
        int r;
        r = $random(seed);
        while (used[r[uc_pkg::var_w-1:0]]) begin
            r = $random(seed);
        end
        used[r[uc_pkg::var_w-1:0]] = 1'b1;
        l.idx = r[uc_pkg::var_w-1:0];
        l.neg = r[uc_pkg::var_w];
    endtask

    task automatic clear_hub();
        apb_access(1'b1, uc_pkg::reg_ctrl, 32'h2);
        used = '{default: 1'b0};
    endtask

    task automatic set_stall(input logic v);
        @(negedge clk);
        stall = v;
        @(posedge clk);
        #1;
    endtask

    // done when at most keep engine literals remain and the queue is empty
    task automatic wait_drained(input int keep);
        logic done;
        int left;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            left = 0;
            for (int i = 0; i < uc_pkg::num_engine; i++) begin
                left += eng_list[i].size();
            end
            done = !out_valid && (left <= keep);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, errors - err_before);
        end
        err_before = errors;
    endtask

    initial begin
        uc_pkg::lit_t l;
        uc_pkg::lit_t opp;
        uc_pkg::lit_t seeds [4];
        clk = 1'b0;
        rst = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        eng_in = '0;
        for (int i = 0; i < uc_pkg::num_engine; i++) begin
            eng_in[i].empty = 1'b1;
        end
        out_ready = 1'b0;
        stall = 1'b0;
        seed = 99867;
        take_seen = '0;
        used = '{default: 1'b0};
        test_num = 0;
        tests_failed = 0;
        err_before = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #1;

        repeat (6) begin
            new_lit(l);
            apb_access(1'b1, uc_pkg::reg_lit, 32'(l));
        end
        wait_drained(0);
        apb_access(1'b0, uc_pkg::reg_count, '0);
        apb_access(1'b0, uc_pkg::reg_status, '0);
        clear_hub();
        end_test("seeds only");

        // each engine repeats a seed, then offers one literal twice
        for (int i = 0; i < 4; i++) begin
            new_lit(seeds[i]);
            apb_access(1'b1, uc_pkg::reg_lit, 32'(seeds[i]));
        end
        for (int i = 0; i < uc_pkg::num_engine; i++) begin
            new_lit(l);
            eng_list[i].push_back(seeds[i]);
            eng_list[i].push_back(l);
            eng_list[i].push_back(l);
        end
        apb_access(1'b1, uc_pkg::reg_ctrl, 32'h1);
        wait_drained(0);
        apb_access(1'b0, uc_pkg::reg_count, '0);
        clear_hub();
        end_test("duplicates");

        for (int i = 0; i < uc_pkg::num_engine; i++) begin
            repeat (4) begin
                new_lit(l);
                eng_list[i].push_back(l);
            end
        end
        apb_access(1'b1, uc_pkg::reg_ctrl, 32'h1);
        wait_drained(0);
        apb_access(1'b0, uc_pkg::reg_status, '0);
        apb_access(1'b0, uc_pkg::reg_count, '0);
        clear_hub();
        end_test("round-robin drain");

        // engine 2 hits the opposite of the first seed, its last literal must stay
        for (int i = 0; i < 3; i++) begin
            new_lit(seeds[i]);
            apb_access(1'b1, uc_pkg::reg_lit, 32'(seeds[i]));
        end
        opp = seeds[0];
        opp.neg = !seeds[0].neg;
        new_lit(l);
        eng_list[2].push_back(l);
        eng_list[2].push_back(opp);
        new_lit(l);
        eng_list[2].push_back(l);
        apb_access(1'b1, uc_pkg::reg_ctrl, 32'h1);
        wait_drained(1);
        repeat (8) @(posedge clk);
        #1;
        apb_access(1'b0, uc_pkg::reg_status, '0);
        eng_list[2].delete();
        clear_hub();
        end_test("conflict");

        set_stall(1'b1);
        for (int i = 0; i < uc_pkg::num_engine; i++) begin
            repeat (3) begin
                new_lit(l);
                eng_list[i].push_back(l);
            end
        end
        repeat (uc_pkg::queue_depth) begin
            new_lit(l);
            apb_access(1'b1, uc_pkg::reg_lit, 32'(l));
        end
        // the next seed waits on a full queue until the sink is released
        new_lit(l);
        fork
            apb_access(1'b1, uc_pkg::reg_lit, 32'(l));
            begin
                repeat (6) @(posedge clk);
                set_stall(1'b0);
            end
        join
        set_stall(1'b1);
        apb_access(1'b1, uc_pkg::reg_ctrl, 32'h1);
        while (pending != uc_pkg::queue_depth) begin
            @(posedge clk);
            #1;
        end
        repeat (6) @(posedge clk);
        #1;
        set_stall(1'b0);
        wait_drained(0);
        apb_access(1'b0, uc_pkg::reg_count, '0);
        clear_hub();
        end_test("back-pressure");

        new_lit(l);
        apb_access(1'b1, uc_pkg::reg_lit, 32'(l));
        opp = l;
        opp.neg = !l.neg;
        apb_access(1'b1, uc_pkg::reg_lit, 32'(opp));
        apb_access(1'b0, uc_pkg::reg_status, '0);
        clear_hub();
        apb_access(1'b0, uc_pkg::reg_status, '0);
        apb_access(1'b0, uc_pkg::reg_count, '0);
        apb_access(1'b1, uc_pkg::reg_lit, 32'(opp));
        wait_drained(0);
        apb_access(1'b0, uc_pkg::reg_count, '0);
        clear_hub();
        end_test("clear");

        $display("tests run %0d, tests failed %0d, errors %0d", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("run timed out after %0d ns before all tests finished", timeout_ns);
        $display("Test failures found");
        $finish;
    end

endmodule

/* uc_top.f */
uc_pkg.sv
uc_apb_regs.sv
uc_arbiter.sv
uc_queue.sv
uc_top.sv
tb_uc_checker.sv
tb_uc_top.sv

/* run.sh */
#!/bin/bash
set -e -o pipefail
cd "$(dirname "$0")"

# build the testbench with the hub underneath it
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_uc_top -f uc_top.f -o sim_uc

./obj_dir/sim_uc | tee sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0
